// File: source/wb_bus_pkg.sv
// Wishbone-side widths, request struct and response struct
`default_nettype none

package wb_bus_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus widths
	//////////////////////////////////////////////////////////////////////

	// Word address, one word is four bytes
	localparam int WB_ADDR_W = 26;
	localparam int WB_DATA_W = 32;
	localparam int WB_SEL_W  = WB_DATA_W / 8;

	// One pipelined request as seen on the strobe
	typedef struct packed {
		logic                 we;
		logic [WB_ADDR_W-1:0] addr;
		logic [WB_DATA_W-1:0] data;
		logic [WB_SEL_W-1:0]  sel;
	} wb_req_t;

	// Returned to the master, ack and err never together
	typedef struct packed {
		logic                 ack;
		logic                 err;
		logic [WB_DATA_W-1:0] data;
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: source/axil_bus_pkg.sv
// AXI-lite widths, channel payload structs, response codes and bridge limits
`default_nettype none

package axil_bus_pkg;

	// Byte address, two bits wider than the Wishbone word address
	localparam int AXI_ADDR_W = 28;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;
	localparam int AXI_PROT_W = 3;

	// Unprivileged, non-secure, data access
	localparam logic [AXI_PROT_W-1:0] AXI_PROT_DATA = 3'b000;

	// Upper bit set means SLVERR or DECERR
	typedef enum logic [1:0] {
		AXIL_OKAY   = 2'b00,
		AXIL_EXOKAY = 2'b01,
		AXIL_SLVERR = 2'b10,
		AXIL_DECERR = 2'b11
	} axil_resp_t;

	// Shared by the AW and AR channels
	typedef struct packed {
		logic [AXI_ADDR_W-1:0] addr;
		logic [AXI_PROT_W-1:0] prot;
	} axil_addr_t;

	typedef struct packed {
		logic [AXI_DATA_W-1:0] data;
		logic [AXI_STRB_W-1:0] strb;
	} axil_wdata_t;

	// B and R channels together, both always ready
	typedef struct packed {
		logic                  bvalid;
		axil_resp_t            bresp;
		logic                  rvalid;
		axil_resp_t            rresp;
		logic [AXI_DATA_W-1:0] rdata;
	} axil_rsp_t;

	//////////////////////////////////////////////////////////////////////
	// Bridge limits
	//////////////////////////////////////////////////////////////////////

	localparam int LG_OUTSTANDING  = 5;
	localparam int OUTSTANDING_MAX = 30;
	// Stall cycles after reset
	localparam int START_HOLD      = 15;

endpackage

`default_nettype wire

// File: source/axil_chan_stage.sv
// Valid/ready holding stage for one AXI-lite request channel
`default_nettype none

module axil_chan_stage #(
	parameter type PAYLOAD_T = axil_bus_pkg::axil_addr_t
) (
	input  wire      i_clk,
	input  wire      i_reset,
	input  wire      i_load,
	input  PAYLOAD_T i_payload,
	output logic     o_valid,
	input  wire      i_ready,
	output PAYLOAD_T o_payload
);

	// Valid rises on load, falls once the slave takes the beat
	// A load in the same cycle as ready keeps valid up for the next beat
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_valid <= 1'b0;
		else if (i_load)
			o_valid <= 1'b1;
		else if (i_ready)
			o_valid <= 1'b0;
	end

	// Payload only changes on load, so it stays put while waiting
	always_ff @(posedge i_clk)
	begin
		if (i_load)
			o_payload <= i_payload;
	end

endmodule

`default_nettype wire

// File: source/axil_req_issue.sv
// Write-address, write-data and read-address channel issue
`default_nettype none

module axil_req_issue (
	input  wire                      i_clk,
	input  wire                      i_reset,
	input  wire                      i_accept,
	input  wb_bus_pkg::wb_req_t      i_req,
	output logic                     o_awvalid,
	input  wire                      i_awready,
	output axil_bus_pkg::axil_addr_t o_aw,
	output logic                     o_wvalid,
	input  wire                      i_wready,
	output axil_bus_pkg::axil_wdata_t o_w,
	output logic                     o_arvalid,
	input  wire                      i_arready,
	output axil_bus_pkg::axil_addr_t o_ar,
	output logic                     o_busy
);

	import axil_bus_pkg::*;

	axil_addr_t  req_addr;
	axil_wdata_t req_wdata;
	logic        wr_load;
	logic        rd_load;

	// Word address to byte address
	assign req_addr  = '{addr: {i_req.addr, 2'b00}, prot: AXI_PROT_DATA};
	assign req_wdata = '{data: i_req.data, strb: i_req.sel};

	// A write needs both AW and W, a read only AR
	assign wr_load = i_accept && i_req.we;
	assign rd_load = i_accept && !i_req.we;

	//////////////////////////////////////////////////////////////////////
	// Channel stages
	//////////////////////////////////////////////////////////////////////

	axil_chan_stage #(.PAYLOAD_T(axil_addr_t)) aw_stage (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_load    (wr_load),
		.i_payload (req_addr),
		.o_valid   (o_awvalid),
		.i_ready   (i_awready),
		.o_payload (o_aw)
	);

	axil_chan_stage #(.PAYLOAD_T(axil_wdata_t)) w_stage (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_load    (wr_load),
		.i_payload (req_wdata),
		.o_valid   (o_wvalid),
		.i_ready   (i_wready),
		.o_payload (o_w)
	);

	axil_chan_stage #(.PAYLOAD_T(axil_addr_t)) ar_stage (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_load    (rd_load),
		.i_payload (req_addr),
		.o_valid   (o_arvalid),
		.i_ready   (i_arready),
		.o_payload (o_ar)
	);

	// Any channel still waiting blocks the next accept
	assign o_busy = (o_awvalid && !i_awready)
		|| (o_wvalid && !i_wready)
		|| (o_arvalid && !i_arready);

endmodule

`default_nettype wire

// File: source/wb_txn_tracker.sv
// Start-up hold, outstanding request count, direction lock, stall and accept
`default_nettype none

module wb_txn_tracker (
	input  wire  i_clk,
	input  wire  i_reset,
	input  wire  i_wb_cyc,
	input  wire  i_wb_stb,
	input  wire  i_wb_we,
	input  wire  i_busy,
	input  wire  i_err_state,
	input  wire  i_ack,
	output logic o_stall,
	output logic o_accept,
	output logic o_pending
);

	import axil_bus_pkg::*;

	localparam int LG_HOLD = $clog2(START_HOLD + 1);

	logic [LG_HOLD-1:0]        hold_cnt;
	logic                      start_hold;
	logic [LG_OUTSTANDING-1:0] outstanding;
	logic                      full;
	logic                      last_we;
	logic                      dir_change;

	//////////////////////////////////////////////////////////////////////
	// Start-up hold
	//////////////////////////////////////////////////////////////////////

	// Counter reloads while reset is held, then counts down to release
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			start_hold <= 1'b1;
			hold_cnt   <= LG_HOLD'(START_HOLD);
		end
		else if (start_hold)
		begin
			if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			else
				start_hold <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stall and accept
	//////////////////////////////////////////////////////////////////////

	// Direction may only change once everything is acknowledged
	assign dir_change = o_pending && (i_wb_we != last_we);

	assign o_stall = start_hold || full || dir_change || i_err_state || i_busy;
	assign o_accept = i_wb_cyc && i_wb_stb && !o_stall;

	// Direction of the most recent accepted request
	always_ff @(posedge i_clk)
	begin
		if (o_accept)
			last_we <= i_wb_we;
	end

	// Outstanding count, dropped on cycle end or error
	always_ff @(posedge i_clk)
	begin
		if (i_reset || start_hold || i_err_state || !i_wb_cyc)
		begin
			outstanding <= '0;
			o_pending   <= 1'b0;
			full        <= 1'b0;
		end
		else
		begin
			case ({o_accept, i_ack})
			2'b10:
			begin
				outstanding <= outstanding + 1'b1;
				o_pending   <= 1'b1;
				// Full once this accept brings the count to the limit
				full <= (outstanding >= LG_OUTSTANDING'(OUTSTANDING_MAX - 1));
			end
			2'b01:
			begin
				outstanding <= outstanding - 1'b1;
				o_pending   <= (outstanding >= LG_OUTSTANDING'(2));
				full        <= 1'b0;
			end
			default:
			begin
				// Accept and ack together leave the count unchanged
			end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/wb_resp_return.sv
// Ack/err/data return, error state and AXI-pending request count
`default_nettype none

module wb_resp_return (
	input  wire                     i_clk,
	input  wire                     i_reset,
	input  wire                     i_wb_cyc,
	input  wire                     i_accept,
	input  wire                     i_pending,
	input  axil_bus_pkg::axil_rsp_t i_axi_rsp,
	output wb_bus_pkg::wb_rsp_t     o_wb_rsp,
	output logic                    o_err_state
);

	import axil_bus_pkg::*;

	logic                      rsp_beat;
	logic                      rsp_ok;
	logic                      rsp_bad;
	logic [LG_OUTSTANDING-1:0] axi_pending;

	// One beat per cycle at most, B and R never both for one direction
	assign rsp_beat = i_axi_rsp.bvalid || i_axi_rsp.rvalid;
	assign rsp_ok   = (i_axi_rsp.bvalid && !i_axi_rsp.bresp[1])
		|| (i_axi_rsp.rvalid && !i_axi_rsp.rresp[1]);
	assign rsp_bad  = (i_axi_rsp.bvalid && i_axi_rsp.bresp[1])
		|| (i_axi_rsp.rvalid && i_axi_rsp.rresp[1]);

	//////////////////////////////////////////////////////////////////////
	// Wishbone return
	//////////////////////////////////////////////////////////////////////

	// Nothing goes back once the master has left or after an error
	// Read data follows the R channel every cycle
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc || o_err_state)
		begin
			o_wb_rsp.ack <= 1'b0;
			o_wb_rsp.err <= 1'b0;
		end
		else
		begin
			o_wb_rsp.ack <= rsp_ok;
			o_wb_rsp.err <= rsp_bad;
		end
		o_wb_rsp.data <= i_axi_rsp.rdata;
	end

	//////////////////////////////////////////////////////////////////////
	// Error state
	//////////////////////////////////////////////////////////////////////

	// Issued on AXI but not yet answered
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			axi_pending <= '0;
		else if (i_accept && !rsp_beat)
			axi_pending <= axi_pending + 1'b1;
		else if (!i_accept && rsp_beat)
			axi_pending <= axi_pending - 1'b1;
	end

	// Held until every AXI request in flight has drained
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_err_state <= 1'b0;
		else if (rsp_bad)
			o_err_state <= 1'b1;
		else if (i_pending && !i_wb_cyc)
			// Cycle abandoned with requests still open
			o_err_state <= 1'b1;
		else if (axi_pending == '0)
			o_err_state <= 1'b0;
	end

endmodule

`default_nettype wire

// File: source/wbaxil_bridge.sv
// Top level of the pipelined Wishbone to AXI-lite bridge
`default_nettype none

module wbaxil_bridge (
	input  wire                                   i_clk,
	input  wire                                   i_reset,
	// Wishbone slave side
	input  wire                                   i_wb_cyc,
	input  wire                                   i_wb_stb,
	input  wire                                   i_wb_we,
	input  wire  [wb_bus_pkg::WB_ADDR_W-1:0]      i_wb_addr,
	input  wire  [wb_bus_pkg::WB_DATA_W-1:0]      i_wb_data,
	input  wire  [wb_bus_pkg::WB_SEL_W-1:0]       i_wb_sel,
	output logic                                  o_wb_stall,
	output logic                                  o_wb_ack,
	output logic                                  o_wb_err,
	output logic [wb_bus_pkg::WB_DATA_W-1:0]      o_wb_data,
	// AXI-lite write address
	output logic                                  o_axi_awvalid,
	input  wire                                   i_axi_awready,
	output logic [axil_bus_pkg::AXI_ADDR_W-1:0]   o_axi_awaddr,
	output logic [axil_bus_pkg::AXI_PROT_W-1:0]   o_axi_awprot,
	// AXI-lite write data
	output logic                                  o_axi_wvalid,
	input  wire                                   i_axi_wready,
	output logic [axil_bus_pkg::AXI_DATA_W-1:0]   o_axi_wdata,
	output logic [axil_bus_pkg::AXI_STRB_W-1:0]   o_axi_wstrb,
	// AXI-lite write response
	input  wire                                   i_axi_bvalid,
	output logic                                  o_axi_bready,
	input  wire  [1:0]                            i_axi_bresp,
	// AXI-lite read address
	output logic                                  o_axi_arvalid,
	input  wire                                   i_axi_arready,
	output logic [axil_bus_pkg::AXI_ADDR_W-1:0]   o_axi_araddr,
	output logic [axil_bus_pkg::AXI_PROT_W-1:0]   o_axi_arprot,
	// AXI-lite read data
	input  wire                                   i_axi_rvalid,
	output logic                                  o_axi_rready,
	input  wire  [axil_bus_pkg::AXI_DATA_W-1:0]   i_axi_rdata,
	input  wire  [1:0]                            i_axi_rresp
);

	import wb_bus_pkg::*;
	import axil_bus_pkg::*;

	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	axil_addr_t  aw;
	axil_wdata_t w;
	axil_addr_t  ar;
	axil_rsp_t   axi_rsp;
	logic        accept;
	logic        busy;
	logic        pending;
	logic        err_state;

	// Bundle the flat bus signals
	assign wb_req  = '{we: i_wb_we, addr: i_wb_addr, data: i_wb_data, sel: i_wb_sel};
	assign axi_rsp = '{bvalid: i_axi_bvalid, bresp: axil_resp_t'(i_axi_bresp),
		rvalid: i_axi_rvalid, rresp: axil_resp_t'(i_axi_rresp), rdata: i_axi_rdata};

	// Responses are never back-pressured
	assign o_axi_bready = 1'b1;
	assign o_axi_rready = 1'b1;

	//////////////////////////////////////////////////////////////////////
	// Request side
	//////////////////////////////////////////////////////////////////////

	wb_txn_tracker tracker_inst (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_wb_we     (i_wb_we),
		.i_busy      (busy),
		.i_err_state (err_state),
		.i_ack       (wb_rsp.ack),
		.o_stall     (o_wb_stall),
		.o_accept    (accept),
		.o_pending   (pending)
	);

	axil_req_issue issue_inst (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_accept  (accept),
		.i_req     (wb_req),
		.o_awvalid (o_axi_awvalid),
		.i_awready (i_axi_awready),
		.o_aw      (aw),
		.o_wvalid  (o_axi_wvalid),
		.i_wready  (i_axi_wready),
		.o_w       (w),
		.o_arvalid (o_axi_arvalid),
		.i_arready (i_axi_arready),
		.o_ar      (ar),
		.o_busy    (busy)
	);

	// Unbundle the request channels
	assign o_axi_awaddr = aw.addr;
	assign o_axi_awprot = aw.prot;
	assign o_axi_wdata  = w.data;
	assign o_axi_wstrb  = w.strb;
	assign o_axi_araddr = ar.addr;
	assign o_axi_arprot = ar.prot;

	//////////////////////////////////////////////////////////////////////
	// Response side
	//////////////////////////////////////////////////////////////////////

	wb_resp_return resp_inst (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_wb_cyc    (i_wb_cyc),
		.i_accept    (accept),
		.i_pending   (pending),
		.i_axi_rsp   (axi_rsp),
		.o_wb_rsp    (wb_rsp),
		.o_err_state (err_state)
	);

	assign o_wb_ack  = wb_rsp.ack;
	assign o_wb_err  = wb_rsp.err;
	assign o_wb_data = wb_rsp.data;

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
// Testbench clock and power-on reset source
`default_nettype none

module tb_clock_gen (
	output logic o_clk,
	output logic o_reset
);

	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period
	initial
	begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;
	end

	// Reset held over two rising edges, released on a falling edge
	initial
	begin
		o_reset = 1'b1;
		repeat (2) @(posedge o_clk);
		@(negedge o_clk);
		o_reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: bench/axil_slave_model.sv
// AXI-lite memory slave with random ready, random response delay and one error address
`default_nettype none

module axil_slave_model #(
	parameter int          ERR_WORD  = 37,
	parameter int          MAX_DELAY = 8,
	parameter logic [31:0] SEED      = 32'h1
) (
	input  wire         i_clk,
	input  wire         i_hold,
	input  wire         i_awvalid,
	output logic        o_awready,
	input  wire  [27:0] i_awaddr,
	input  wire         i_wvalid,
	output logic        o_wready,
	input  wire  [31:0] i_wdata,
	input  wire  [3:0]  i_wstrb,
	output logic        o_bvalid,
	output logic [1:0]  o_bresp,
	input  wire         i_arvalid,
	output logic        o_arready,
	input  wire  [27:0] i_araddr,
	output logic        o_rvalid,
	output logic [1:0]  o_rresp,
	output logic [31:0] o_rdata
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] mem [64];
	logic [27:0] aw_q [$];
	logic [35:0] w_q [$];
	// Response beat is {is_read, resp, data}, due_q holds its release cycle
	logic [34:0] rsp_q [$];
	int          due_q [$];
	int          cycle_no;
	integer      seed;

	// Same fill as the testbench shadow, every address bit shows
	function automatic logic [31:0] fill_word(input int idx);
		fill_word = {8'h5a, idx[7:0], ~idx[7:0], 8'(idx * 7)};
	endfunction

	initial
	begin
		logic [27:0] waddr;
		logic [35:0] wbeat;
		logic [34:0] beat;
		int          b;
		seed     = SEED;
		cycle_no = 0;
		for (b = 0; b < 64; b++)
			mem[b] = fill_word(b);
		o_awready = 1'b0;
		o_wready  = 1'b0;
		o_arready = 1'b0;
		o_bvalid  = 1'b0;
		o_rvalid  = 1'b0;
		o_bresp   = 2'b00;
		o_rresp   = 2'b00;
		o_rdata   = '0;
		forever
		begin
			@(negedge i_clk);
			cycle_no++;
			// Ready about three cycles in four
			o_awready = ($random(seed) & 3) != 0;
			o_wready  = ($random(seed) & 3) != 0;
			o_arready = ($random(seed) & 3) != 0;
			o_bvalid  = 1'b0;
			o_rvalid  = 1'b0;
			// Responses leave in order, one beat per cycle
			if (!i_hold && rsp_q.size() > 0 && due_q[0] <= cycle_no)
			begin
				beat = rsp_q[0];
				rsp_q.delete(0);
				due_q.delete(0);
				if (beat[34])
				begin
					o_rvalid = 1'b1;
					o_rresp  = beat[33:32];
					o_rdata  = beat[31:0];
				end
				else
				begin
					o_bvalid = 1'b1;
					o_bresp  = beat[33:32];
				end
			end
			// Handshakes seen just before the rising edge
			#3;
			if (i_awvalid && o_awready)
				aw_q.push_back(i_awaddr);
			if (i_wvalid && o_wready)
				w_q.push_back({i_wdata, i_wstrb});
			// Write happens once address and data have both arrived
			if (aw_q.size() > 0 && w_q.size() > 0)
			begin
				waddr = aw_q[0];
				wbeat = w_q[0];
				aw_q.delete(0);
				w_q.delete(0);
				if (waddr[27:2] == ERR_WORD)
					rsp_q.push_back({1'b0, 2'b10, 32'h0});
				else
				begin
					for (b = 0; b < 4; b++)
						if (wbeat[b])
							mem[waddr[7:2]][8*b +: 8] = wbeat[4 + 8*b +: 8];
					rsp_q.push_back({1'b0, 2'b00, 32'h0});
				end
				due_q.push_back(cycle_no + 1 + ($random(seed) & (MAX_DELAY - 1)));
			end
			if (i_arvalid && o_arready)
			begin
				if (i_araddr[27:2] == ERR_WORD)
					rsp_q.push_back({1'b1, 2'b10, 32'h0});
				else
					rsp_q.push_back({1'b1, 2'b00, mem[i_araddr[7:2]]});
				due_q.push_back(cycle_no + 1 + ($random(seed) & (MAX_DELAY - 1)));
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/wbaxil_bridge_tb.sv
// Testbench top: Wishbone driver, shadow memory model, checks, watchdog and report
`default_nettype none

module wbaxil_bridge_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import wb_bus_pkg::*;
	import axil_bus_pkg::*;

	localparam logic [31:0] SEED_BASE       = 32'h317e49b5;
	localparam logic [25:0] ERR_WORD        = 26'd37;
	localparam int          SLAVE_MAX_DELAY = 8;
	localparam int          TXN_BUDGET      = 400;
	// Most requests the bridge may hold in flight
	localparam int          MAX_IN_FLIGHT   = 30;
	// Each transaction may wait for ready, delay and the response path
	localparam int WATCHDOG_NS = (TXN_BUDGET * (SLAVE_MAX_DELAY + 8) + 500) * 8;

	logic        clk;
	logic        reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [25:0] wb_addr;
	logic [31:0] wb_wdata;
	logic [3:0]  wb_sel;
	logic        wb_stall;
	logic        wb_ack;
	logic        wb_err;
	logic [31:0] wb_rdata;
	logic        axi_awvalid;
	logic        axi_awready;
	logic [27:0] axi_awaddr;
	logic [2:0]  axi_awprot;
	logic        axi_wvalid;
	logic        axi_wready;
	logic [31:0] axi_wdata;
	logic [3:0]  axi_wstrb;
	logic        axi_bvalid;
	logic        axi_bready;
	logic [1:0]  axi_bresp;
	logic        axi_arvalid;
	logic        axi_arready;
	logic [27:0] axi_araddr;
	logic [2:0]  axi_arprot;
	logic        axi_rvalid;
	logic        axi_rready;
	logic [31:0] axi_rdata;
	logic [1:0]  axi_rresp;
	logic        hold_rsp;

	//////////////////////////////////////////////////////////////////////
	// Model state
	//////////////////////////////////////////////////////////////////////

	logic [31:0] shadow [64];
	// Expected Wishbone responses in request order
	bit          exp_we [$];
	bit          exp_err [$];
	logic [31:0] exp_data [$];
	// Expected AXI channel payloads in issue order
	logic [27:0] aw_exp [$];
	logic [35:0] w_exp [$];
	logic [27:0] ar_exp [$];
	logic        accepted_now;
	integer      seed;
	int          errors;
	int          errs_seen;
	int          acks_seen;

	tb_clock_gen clock_inst (
		.o_clk   (clk),
		.o_reset (reset)
	);

	wbaxil_bridge wbaxil_bridge_inst (
		.i_clk         (clk),
		.i_reset       (reset),
		.i_wb_cyc      (wb_cyc),
		.i_wb_stb      (wb_stb),
		.i_wb_we       (wb_we),
		.i_wb_addr     (wb_addr),
		.i_wb_data     (wb_wdata),
		.i_wb_sel      (wb_sel),
		.o_wb_stall    (wb_stall),
		.o_wb_ack      (wb_ack),
		.o_wb_err      (wb_err),
		.o_wb_data     (wb_rdata),
		.o_axi_awvalid (axi_awvalid),
		.i_axi_awready (axi_awready),
		.o_axi_awaddr  (axi_awaddr),
		.o_axi_awprot  (axi_awprot),
		.o_axi_wvalid  (axi_wvalid),
		.i_axi_wready  (axi_wready),
		.o_axi_wdata   (axi_wdata),
		.o_axi_wstrb   (axi_wstrb),
		.i_axi_bvalid  (axi_bvalid),
		.o_axi_bready  (axi_bready),
		.i_axi_bresp   (axi_bresp),
		.o_axi_arvalid (axi_arvalid),
		.i_axi_arready (axi_arready),
		.o_axi_araddr  (axi_araddr),
		.o_axi_arprot  (axi_arprot),
		.i_axi_rvalid  (axi_rvalid),
		.o_axi_rready  (axi_rready),
		.i_axi_rdata   (axi_rdata),
		.i_axi_rresp   (axi_rresp)
	);

	axil_slave_model #(
		.ERR_WORD  (37),
		.MAX_DELAY (SLAVE_MAX_DELAY),
		.SEED      (SEED_BASE + 32'd1)
	) slave_inst (
		.i_clk     (clk),
		.i_hold    (hold_rsp),
		.i_awvalid (axi_awvalid),
		.o_awready (axi_awready),
		.i_awaddr  (axi_awaddr),
		.i_wvalid  (axi_wvalid),
		.o_wready  (axi_wready),
		.i_wdata   (axi_wdata),
		.i_wstrb   (axi_wstrb),
		.o_bvalid  (axi_bvalid),
		.o_bresp   (axi_bresp),
		.i_arvalid (axi_arvalid),
		.o_arready (axi_arready),
		.i_araddr  (axi_araddr),
		.o_rvalid  (axi_rvalid),
		.o_rresp   (axi_rresp),
		.o_rdata   (axi_rdata)
	);

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] fill_word(input int idx);
		fill_word = {8'h5a, idx[7:0], ~idx[7:0], 8'(idx * 7)};
	endfunction

	// Random word inside the slave memory, never the error address
	function automatic logic [25:0] pick_addr();
		logic [25:0] a;
		a = 26'($random(seed) & 63);
		if (a == ERR_WORD)
			a = a + 26'd1;
		return a;
	endfunction

	task automatic compare_value(input string name, input logic [35:0] got,
		input logic [35:0] want);
		assert (got == want)
		else
		begin
			$display("ERR %s: got %h, expected %h at %0t", name, got, want, $time);
			errors++;
		end
	endtask

	task automatic expect_true(input bit cond, input string what);
		assert (cond)
		else
		begin
			$display("Check failed at %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic drop_expected();
		exp_we.delete();
		exp_err.delete();
		exp_data.delete();
	endtask

	// Samples just before the rising edge, then returns on the next falling edge
	task automatic tick();
		int b;
		#3;
		accepted_now = wb_cyc && wb_stb && !wb_stall;
		// Registered responses belong to earlier accepts
		if (wb_ack)
		begin
			acks_seen++;
			expect_true(exp_we.size() > 0, "ack arrived with no request outstanding");
			if (exp_we.size() > 0)
			begin
				expect_true(!exp_err[0], "ack given where an error was due");
				if (!exp_we[0])
					compare_value("o_wb_data", wb_rdata, exp_data[0]);
				exp_we.delete(0);
				exp_err.delete(0);
				exp_data.delete(0);
			end
		end
		if (wb_err)
		begin
			errs_seen++;
			expect_true(exp_we.size() > 0 && exp_err[0], "err returned for a good request");
			// Everything still open is abandoned by the bridge
			drop_expected();
		end
		if (accepted_now)
		begin
			if (wb_we)
			begin
				if (wb_addr != ERR_WORD)
					for (b = 0; b < 4; b++)
						if (wb_sel[b])
							shadow[wb_addr[5:0]][8*b +: 8] = wb_wdata[8*b +: 8];
				aw_exp.push_back({wb_addr, 2'b00});
				w_exp.push_back({wb_wdata, wb_sel});
				exp_data.push_back('0);
			end
			else
			begin
				ar_exp.push_back({wb_addr, 2'b00});
				exp_data.push_back(shadow[wb_addr[5:0]]);
			end
			exp_we.push_back(wb_we);
			exp_err.push_back(wb_addr == ERR_WORD);
		end
		// AXI payloads at each handshake
		if (axi_awvalid && axi_awready)
		begin
			expect_true(aw_exp.size() > 0, "AW handshake with no write accepted");
			if (aw_exp.size() > 0)
			begin
				compare_value("o_axi_awaddr", axi_awaddr, aw_exp[0]);
				aw_exp.delete(0);
			end
			compare_value("o_axi_awprot", axi_awprot, 3'b000);
		end
		if (axi_wvalid && axi_wready)
		begin
			expect_true(w_exp.size() > 0, "W handshake with no write accepted");
			if (w_exp.size() > 0)
			begin
				compare_value("o_axi_wdata", axi_wdata, w_exp[0][35:4]);
				compare_value("o_axi_wstrb", axi_wstrb, w_exp[0][3:0]);
				w_exp.delete(0);
			end
		end
		if (axi_arvalid && axi_arready)
		begin
			expect_true(ar_exp.size() > 0, "AR handshake with no read accepted");
			if (ar_exp.size() > 0)
			begin
				compare_value("o_axi_araddr", axi_araddr, ar_exp[0]);
				ar_exp.delete(0);
			end
			compare_value("o_axi_arprot", axi_arprot, 3'b000);
		end
		// Responses are never back-pressured
		if (axi_bvalid)
			compare_value("o_axi_bready", axi_bready, 1);
		if (axi_rvalid)
			compare_value("o_axi_rready", axi_rready, 1);
		// Direction lock and outstanding limit
		if (axi_arvalid)
			expect_true(!(exp_we.size() > 0 && exp_we[0]),
				"AR issued while writes are unacknowledged");
		if (axi_awvalid)
			expect_true(!(exp_we.size() > 0 && !exp_we[0]),
				"AW issued while reads are unacknowledged");
		expect_true(exp_we.size() <= MAX_IN_FLIGHT, "more than 30 requests outstanding");
		@(negedge clk);
	endtask

	// Holds one request on the strobe until the bridge takes it
	task automatic issue(input logic we, input logic [25:0] addr);
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_addr  = addr;
		wb_wdata = $random(seed);
		wb_sel   = we ? 4'($random(seed)) : 4'hf;
		tick();
		while (!accepted_now)
			tick();
	endtask

	task automatic drain();
		wb_stb = 1'b0;
		while (exp_we.size() > 0)
			tick();
		tick();
	endtask

	task automatic report_test(input int num, input string name, input int start_errors);
		if (errors == start_errors)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, errors - start_errors);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [25:0] addrs [16];
		int          i;
		int          start;
		int          errs_start;
		seed      = SEED_BASE;
		errors    = 0;
		errs_seen = 0;
		acks_seen = 0;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_addr   = '0;
		wb_wdata  = '0;
		wb_sel    = '0;
		hold_rsp  = 1'b0;
		accepted_now = 1'b0;
		for (i = 0; i < 64; i++)
			shadow[i] = fill_word(i);
		wait (!reset);
		@(negedge clk);

		// 1: quiet bus and stall right after reset
		start = errors;
		compare_value("o_axi_awvalid", axi_awvalid, 0);
		compare_value("o_axi_wvalid", axi_wvalid, 0);
		compare_value("o_axi_arvalid", axi_arvalid, 0);
		compare_value("o_wb_ack", wb_ack, 0);
		compare_value("o_wb_err", wb_err, 0);
		compare_value("o_wb_stall", wb_stall, 1);
		for (i = 0; i < 40 && wb_stall; i++)
			tick();
		expect_true(!wb_stall, "stall stayed high after the start-up hold");
		report_test(1, "reset and start-up hold", start);

		// 2: writes then reads of the same words
		start  = errors;
		wb_cyc = 1'b1;
		for (i = 0; i < 16; i++)
		begin
			addrs[i] = pick_addr();
			issue(1'b1, addrs[i]);
		end
		drain();
		for (i = 0; i < 16; i++)
			issue(1'b0, addrs[i]);
		drain();
		report_test(2, "write then read back", start);

		// 3: mixed traffic
		start = errors;
		for (i = 0; i < 150; i++)
			issue(1'($random(seed)), pick_addr());
		drain();
		report_test(3, "mixed random traffic", start);

		// 4: responses held back, stall must cap the count at 30
		start    = errors;
		hold_rsp = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b0;
		wb_sel   = 4'hf;
		wb_addr  = pick_addr();
		for (i = 0; i < 100; i++)
		begin
			tick();
			if (accepted_now)
				wb_addr = pick_addr();
		end
		compare_value("outstanding", exp_we.size(), MAX_IN_FLIGHT);
		hold_rsp = 1'b0;
		drain();
		report_test(4, "outstanding limit", start);

		// 5: one error response, then recovery
		start      = errors;
		errs_start = errs_seen;
		for (i = 0; i < 4; i++)
			issue(1'b1, pick_addr());
		issue(1'b1, ERR_WORD);
		for (i = 0; i < 4; i++)
			issue(1'b1, pick_addr());
		drain();
		compare_value("o_wb_err count", errs_seen - errs_start, 1);
		for (i = 0; i < 8; i++)
			issue(1'b0, pick_addr());
		drain();
		report_test(5, "error response", start);

		// 6: cycle dropped with writes still open
		start    = errors;
		hold_rsp = 1'b1;
		for (i = 0; i < 6; i++)
			issue(1'b1, pick_addr());
		wb_stb = 1'b0;
		tick();
		tick();
		wb_cyc = 1'b0;
		drop_expected();
		for (i = 0; i < 8; i++)
			tick();
		hold_rsp = 1'b0;
		for (i = 0; i < 20; i++)
			tick();
		wb_cyc = 1'b1;
		for (i = 0; i < 20; i++)
			issue(1'($random(seed)), pick_addr());
		drain();
		report_test(6, "abandoned cycle", start);

		$display("6 tests run, %0d checks failed, %0d acks, %0d errs",
			errors, acks_seen, errs_seen);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: wbaxil_bridge.f
source/wb_bus_pkg.sv
source/axil_bus_pkg.sv
source/axil_chan_stage.sv
source/axil_req_issue.sv
source/wb_txn_tracker.sv
source/wb_resp_return.sv
source/wbaxil_bridge.sv
bench/tb_clock_gen.sv
bench/axil_slave_model.sv
bench/wbaxil_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the bridge testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module wbaxil_bridge_tb -f wbaxil_bridge.f -o wbaxil_bridge_sim

./obj_dir/wbaxil_bridge_sim | tee sim.log

if grep -q "TEST PASSED" sim.log; then
	exit 0
else
	exit 1
fi
